// File: hw/mm_ram_pkg.sv
// package with the address map, data widths, target enum and request structs
package mm_ram_pkg;

  // data path widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // address map of the control registers
  localparam logic [31:0] PRINT_ADDR       = 32'h1000_0000;
  localparam logic [31:0] TEST_STATUS_ADDR = 32'h2000_0000;
  localparam logic [31:0] EXIT_ADDR        = 32'h2000_0004;
  localparam logic [31:0] EXIT_ZERO_ADDR   = 32'h2000_0010;
  localparam logic [31:0] TIMER_MASK_ADDR  = 32'h1500_0000;
  localparam logic [31:0] TIMER_CNT_ADDR   = 32'h1500_0004;

  // values written to the test status register
  localparam logic [31:0] TEST_PASS_CODE = 32'd123456789;
  localparam logic [31:0] TEST_FAIL_CODE = 32'd1;

  // interrupt id used for the timer and for its acknowledge
  localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

  // block that answers a request
  typedef enum logic [2:0] {
    TGT_RAM,
    TGT_TIMER,
    TGT_CTRL,
    TGT_NONE
  } tgt_e;

  // request from the core, 69 bits
  typedef struct packed {
    logic [31:0]       addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } data_req_t;

  // write part of a bank access, 37 bits, shared by all banks
  typedef struct packed {
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } bank_wr_t;

endpackage

// File: hw/mm_addr_decode.sv
// address decoder: RAM bank select and index, control-register strobes, response target
module mm_addr_decode #(
  parameter int unsigned RAM_ADDR_WIDTH = 12,
  parameter int unsigned NUM_BANKS      = 4
) (
  input  logic                                  req_valid_i,
  input  mm_ram_pkg::data_req_t                 req_i,

  output logic [NUM_BANKS-1:0]                  bank_sel_o,
  output logic [RAM_ADDR_WIDTH-3-$clog2(NUM_BANKS):0] bank_idx_o,
  output mm_ram_pkg::bank_wr_t                  bank_wr_o,

  output logic                                  print_o,
  output logic                                  status_o,
  output logic                                  exit_o,
  output logic                                  exit_zero_o,
  output logic                                  timer_mask_we_o,
  output logic                                  timer_cnt_we_o,
  output logic [mm_ram_pkg::DATA_W-1:0]         wdata_o,

  output mm_ram_pkg::tgt_e                      tgt_o,
  output logic [$clog2(NUM_BANKS)-1:0]          bank_o
);

  import mm_ram_pkg::*;

  localparam int unsigned BANK_W = $clog2(NUM_BANKS);
  localparam int unsigned IDX_W  = RAM_ADDR_WIDTH - 2 - BANK_W;

  logic in_ram;

  // byte address below 2**RAM_ADDR_WIDTH
  assign in_ram = (req_i.addr[31:RAM_ADDR_WIDTH] == '0);

  // word interleaving: low word bits pick the bank, the rest the row
  assign bank_o     = req_i.addr[2 +: BANK_W];
  assign bank_idx_o = req_i.addr[2 + BANK_W +: IDX_W];

  // write data goes to all banks, only the selected one acts on it
  assign bank_wr_o.we    = req_i.we;
  assign bank_wr_o.be    = req_i.be;
  assign bank_wr_o.wdata = req_i.wdata;
  assign wdata_o         = req_i.wdata;

  always_comb begin
    bank_sel_o      = '0;
    print_o         = 1'b0;
    status_o        = 1'b0;
    exit_o          = 1'b0;
    exit_zero_o     = 1'b0;
    timer_mask_we_o = 1'b0;
    timer_cnt_we_o  = 1'b0;
    // tgt_o names the block that returns read data
    tgt_o           = TGT_NONE;

    if (req_valid_i) begin
      if (in_ram) begin
        bank_sel_o[bank_o] = 1'b1;
        // RAM writes answer with zero data
        if (!req_i.we) begin
          tgt_o = TGT_RAM;
        end
      end else if (!req_i.we) begin
        if (req_i.addr == TIMER_CNT_ADDR) begin
          tgt_o = TGT_TIMER;
        end
      end else begin
        tgt_o = TGT_CTRL;
        case (req_i.addr)
          PRINT_ADDR:       print_o = 1'b1;
          TEST_STATUS_ADDR: status_o = 1'b1;
          EXIT_ADDR:        exit_o = 1'b1;
          EXIT_ZERO_ADDR:   exit_zero_o = 1'b1;
          TIMER_MASK_ADDR:  timer_mask_we_o = 1'b1;
          TIMER_CNT_ADDR:   timer_cnt_we_o = 1'b1;
          // unmapped write, dropped
          default:          tgt_o = TGT_NONE;
        endcase
      end
    end
  end

  // banks never see two selects at once
  bank_sel_onehot: assert final ($onehot0(bank_sel_o))
    else $error("more than one bank selected: %b", bank_sel_o);

endmodule

// File: hw/mm_ram_bank.sv
// one word-wide RAM bank with byte-enable writes and registered read data
module mm_ram_bank #(
  parameter int unsigned RAM_ADDR_WIDTH = 12,
  parameter int unsigned NUM_BANKS      = 4
) (
  input  logic                                        clk_i,
  input  logic                                        sel_i,
  input  logic [RAM_ADDR_WIDTH-3-$clog2(NUM_BANKS):0] idx_i,
  input  mm_ram_pkg::bank_wr_t                        wr_i,
  output logic [mm_ram_pkg::DATA_W-1:0]               rdata_o
);

  import mm_ram_pkg::*;

  localparam int unsigned BANK_W = $clog2(NUM_BANKS);
  localparam int unsigned IDX_W  = RAM_ADDR_WIDTH - 2 - BANK_W;
  localparam int unsigned DEPTH  = 2 ** IDX_W;

  logic [DATA_W-1:0] mem_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (wr_i.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (wr_i.be[b]) begin
            mem_q[idx_i][8*b +: 8] <= wr_i.wdata[8*b +: 8];
          end
        end
      end else begin
        // read port, data one cycle after the select
        rdata_o <= mem_q[idx_i];
      end
    end
  end

  // a selected write must change at least one byte
  write_has_be: assert property (
    @(posedge clk_i) (sel_i && wr_i.we) |-> (wr_i.be != '0)
  ) else $error("bank write with empty byte enable");

endmodule

// File: hw/mm_ctrl_regs.sv
// print, test status and exit pulses and the countdown timer with its interrupt
module mm_ctrl_regs (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // one-cycle strobes from the decoder
  input  logic                          print_i,
  input  logic                          status_i,
  input  logic                          exit_i,
  input  logic                          exit_zero_i,
  input  logic                          timer_mask_we_i,
  input  logic                          timer_cnt_we_i,
  input  logic [mm_ram_pkg::DATA_W-1:0] wdata_i,

  input  logic                          irq_ack_i,
  input  logic [4:0]                    irq_id_i,
  output logic                          irq_timer_o,
  output logic [mm_ram_pkg::DATA_W-1:0] timer_cnt_o,

  output logic                          print_valid_o,
  output logic [mm_ram_pkg::DATA_W-1:0] print_wdata_o,
  output logic                          tests_passed_o,
  output logic                          tests_failed_o,
  output logic                          exit_valid_o,
  output logic [mm_ram_pkg::DATA_W-1:0] exit_value_o
);

  import mm_ram_pkg::*;

  logic [DATA_W-1:0] timer_mask_q;
  logic [DATA_W-1:0] timer_cnt_q;
  logic              irq_timer_q;
  logic              timer_wr;
  logic              timer_expire;
  logic              irq_ack_match;

  // pseudo peripherals pulse in the cycle of the write
  assign print_valid_o  = print_i;
  assign print_wdata_o  = print_i ? wdata_i : '0;
  assign tests_passed_o = status_i && (wdata_i == TEST_PASS_CODE);
  assign tests_failed_o = status_i && (wdata_i == TEST_FAIL_CODE);
  assign exit_valid_o   = exit_i || exit_zero_i;
  assign exit_value_o   = exit_i ? wdata_i : '0;

  // any timer write holds the count for that cycle
  assign timer_wr      = timer_mask_we_i || timer_cnt_we_i;
  assign timer_expire  = !timer_wr && (timer_cnt_q == DATA_W'(1));
  assign irq_ack_match = irq_ack_i && (irq_id_i == TIMER_IRQ_ID);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      timer_mask_q <= '0;
    end else if (timer_mask_we_i) begin
      timer_mask_q <= wdata_i;
    end
  end

  // countdown that stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      timer_cnt_q <= '0;
    end else if (timer_cnt_we_i) begin
      timer_cnt_q <= wdata_i;
    end else if (!timer_wr && (timer_cnt_q != '0)) begin
      timer_cnt_q <= timer_cnt_q - DATA_W'(1);
    end
  end

  // set on the 1 to 0 step when unmasked
  // an ack of the timer id wins over a new expiry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_timer_q <= 1'b0;
    end else if (irq_ack_match) begin
      irq_timer_q <= 1'b0;
    end else if (timer_expire && timer_mask_q[TIMER_IRQ_ID]) begin
      irq_timer_q <= 1'b1;
    end
  end

  assign irq_timer_o = irq_timer_q;
  assign timer_cnt_o = timer_cnt_q;

  // interrupt only rises when the mask allowed it on the edge before
  irq_needs_mask: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(irq_timer_q) |-> $past(timer_mask_q[TIMER_IRQ_ID])
  ) else $error("timer interrupt raised while masked");

endmodule

// File: hw/mm_resp_mux.sv
// response mux: registers the request target and returns rvalid and read data a cycle later
module mm_resp_mux #(
  parameter int unsigned NUM_BANKS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         req_valid_i,
  input  mm_ram_pkg::tgt_e                             tgt_i,
  input  logic [$clog2(NUM_BANKS)-1:0]                 bank_i,
  input  logic [NUM_BANKS-1:0][mm_ram_pkg::DATA_W-1:0] bank_rdata_i,
  input  logic [mm_ram_pkg::DATA_W-1:0]                timer_cnt_i,
  output logic                                         rvalid_o,
  output logic [mm_ram_pkg::DATA_W-1:0]                rdata_o
);

  import mm_ram_pkg::*;

  localparam int unsigned BANK_W = $clog2(NUM_BANKS);

  logic              rvalid_q;
  tgt_e              tgt_q;
  logic [BANK_W-1:0] bank_q;
  logic [DATA_W-1:0] timer_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      tgt_q    <= TGT_NONE;
      bank_q   <= '0;
    end else begin
      rvalid_q <= req_valid_i;
      tgt_q    <= tgt_i;
      bank_q   <= bank_i;
    end
  end

  // count as seen in the request cycle
  always_ff @(posedge clk_i) begin
    timer_cnt_q <= timer_cnt_i;
  end

  always_comb begin
    case (tgt_q)
      TGT_RAM:   rdata_o = bank_rdata_i[bank_q];
      TGT_TIMER: rdata_o = timer_cnt_q;
      default:   rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;

  // every response belongs to a request one cycle earlier
  rvalid_after_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $past(req_valid_i)
  ) else $error("rvalid without a request in the previous cycle");

endmodule

// File: hw/mm_ram_top.sv
// top level of the memory-mapped RAM: decoder, interleaved banks, control registers, response mux
module mm_ram_top #(
  parameter int unsigned RAM_ADDR_WIDTH = 12,
  parameter int unsigned NUM_BANKS      = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          data_req_valid_i,
  input  mm_ram_pkg::data_req_t         data_req_i,
  output logic                          data_gnt_o,
  output logic                          data_rvalid_o,
  output logic [mm_ram_pkg::DATA_W-1:0] data_rdata_o,

  input  logic                          irq_ack_i,
  input  logic [4:0]                    irq_id_i,
  output logic                          irq_timer_o,

  output logic                          print_valid_o,
  output logic [mm_ram_pkg::DATA_W-1:0] print_wdata_o,
  output logic                          tests_passed_o,
  output logic                          tests_failed_o,
  output logic                          exit_valid_o,
  output logic [mm_ram_pkg::DATA_W-1:0] exit_value_o
);

  import mm_ram_pkg::*;

  localparam int unsigned BANK_W = $clog2(NUM_BANKS);
  localparam int unsigned IDX_W  = RAM_ADDR_WIDTH - 2 - BANK_W;

  // decoder to banks
  logic [NUM_BANKS-1:0] bank_sel;
  logic [IDX_W-1:0]     bank_idx;
  bank_wr_t             bank_wr;

  // decoder to control registers
  logic              print_stb;
  logic              status_stb;
  logic              exit_stb;
  logic              exit_zero_stb;
  logic              timer_mask_we;
  logic              timer_cnt_we;
  logic [DATA_W-1:0] ctrl_wdata;

  // decoder and sources to response mux
  tgt_e                              req_tgt;
  logic [BANK_W-1:0]                 req_bank;
  logic [NUM_BANKS-1:0][DATA_W-1:0]  bank_rdata;
  logic [DATA_W-1:0]                 timer_cnt;

  // no back-pressure, every request is taken at once
  assign data_gnt_o = data_req_valid_i;

  mm_addr_decode #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH),
    .NUM_BANKS     (NUM_BANKS)
  ) i_mm_addr_decode (
    .req_valid_i    (data_req_valid_i),
    .req_i          (data_req_i),
    .bank_sel_o     (bank_sel),
    .bank_idx_o     (bank_idx),
    .bank_wr_o      (bank_wr),
    .print_o        (print_stb),
    .status_o       (status_stb),
    .exit_o         (exit_stb),
    .exit_zero_o    (exit_zero_stb),
    .timer_mask_we_o(timer_mask_we),
    .timer_cnt_we_o (timer_cnt_we),
    .wdata_o        (ctrl_wdata),
    .tgt_o          (req_tgt),
    .bank_o         (req_bank)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    mm_ram_bank #(
      .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH),
      .NUM_BANKS     (NUM_BANKS)
    ) i_mm_ram_bank (
      .clk_i  (clk_i),
      .sel_i  (bank_sel[b]),
      .idx_i  (bank_idx),
      .wr_i   (bank_wr),
      .rdata_o(bank_rdata[b])
    );
  end

  mm_ctrl_regs i_mm_ctrl_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .print_i        (print_stb),
    .status_i       (status_stb),
    .exit_i         (exit_stb),
    .exit_zero_i    (exit_zero_stb),
    .timer_mask_we_i(timer_mask_we),
    .timer_cnt_we_i (timer_cnt_we),
    .wdata_i        (ctrl_wdata),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i),
    .irq_timer_o    (irq_timer_o),
    .timer_cnt_o    (timer_cnt),
    .print_valid_o  (print_valid_o),
    .print_wdata_o  (print_wdata_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

  mm_resp_mux #(
    .NUM_BANKS(NUM_BANKS)
  ) i_mm_resp_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (data_req_valid_i),
    .tgt_i       (req_tgt),
    .bank_i      (req_bank),
    .bank_rdata_i(bank_rdata),
    .timer_cnt_i (timer_cnt),
    .rvalid_o    (data_rvalid_o),
    .rdata_o     (data_rdata_o)
  );

endmodule

// File: tests/mm_ram_model.svh
// testbench reference model: RAM contents, timer, interrupt and expected responses
`ifndef MM_RAM_MODEL_SVH
`define MM_RAM_MODEL_SVH

// pulses expected in the cycle of a write
typedef struct packed {
  logic        print;
  logic        passed;
  logic        failed;
  logic        exit_v;
  logic [31:0] exit_value;
} pulse_t;

// model state, one word per RAM word address
logic [31:0] ram_m [RAM_WORDS];
logic [31:0] timer_cnt_m;
logic [31:0] timer_mask_m;
logic        irq_m;

function automatic bit addr_in_ram(logic [31:0] addr);
  return addr < RAM_BYTES;
endfunction

// data returned one cycle after the request
function automatic logic [31:0] expected_rdata(data_req_t req);
  if (req.we) begin
    return '0;
  end
  if (addr_in_ram(req.addr)) begin
    return ram_m[req.addr[RAM_AW-1:2]];
  end
  // timer count as seen in the request cycle
  if (req.addr == TIMER_CNT_ADDR) begin
    return timer_cnt_m;
  end
  return '0;
endfunction

function automatic pulse_t expected_pulses(logic valid, data_req_t req);
  pulse_t p;
  bit     wr;
  p  = '0;
  wr = valid && req.we;
  p.print  = wr && (req.addr == PRINT_ADDR);
  p.passed = wr && (req.addr == TEST_STATUS_ADDR) && (req.wdata == TEST_PASS_CODE);
  p.failed = wr && (req.addr == TEST_STATUS_ADDR) && (req.wdata == TEST_FAIL_CODE);
  p.exit_v = wr && ((req.addr == EXIT_ADDR) || (req.addr == EXIT_ZERO_ADDR));
  if (wr && (req.addr == EXIT_ADDR)) begin
    p.exit_value = req.wdata;
  end
  return p;
endfunction

// state update at the clock edge that ends the request cycle
function automatic void advance_model(logic valid, data_req_t req, logic ack, logic [4:0] id);
  bit wr;
  bit mask_wr;
  bit cnt_wr;
  wr      = valid && req.we;
  mask_wr = wr && (req.addr == TIMER_MASK_ADDR);
  cnt_wr  = wr && (req.addr == TIMER_CNT_ADDR);
  if (wr && addr_in_ram(req.addr)) begin
    for (int b = 0; b < 4; b++) begin
      if (req.be[b]) begin
        ram_m[req.addr[RAM_AW-1:2]][8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
  end
  // ack of the timer id beats a new expiry
  if (ack && (id == TIMER_IRQ_ID)) begin
    irq_m = 1'b0;
  end else if (!mask_wr && !cnt_wr && (timer_cnt_m == 1) && timer_mask_m[TIMER_IRQ_ID]) begin
    irq_m = 1'b1;
  end
  if (cnt_wr) begin
    timer_cnt_m = req.wdata;
  end else if (!mask_wr && (timer_cnt_m != 0)) begin
    timer_cnt_m = timer_cnt_m - 1;
  end
  if (mask_wr) begin
    timer_mask_m = req.wdata;
  end
endfunction

`endif

// File: tests/mm_ram_tb.sv
// testbench for mm_ram_top with clock, reset, random stimulus, model checks and timeout
module mm_ram_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import mm_ram_pkg::*;

  localparam int unsigned RAM_AW         = 10;
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned RAM_BYTES      = 2 ** RAM_AW;
  localparam int unsigned RAM_WORDS      = RAM_BYTES / 4;
  localparam int unsigned TIMEOUT_CYCLES = 6000;

  logic              clk_i;
  logic              rst_ni;
  logic              data_req_valid_i;
  data_req_t         data_req_i;
  logic              data_gnt_o;
  logic              data_rvalid_o;
  logic [DATA_W-1:0] data_rdata_o;
  logic              irq_ack_i;
  logic [4:0]        irq_id_i;
  logic              irq_timer_o;
  logic              print_valid_o;
  logic [DATA_W-1:0] print_wdata_o;
  logic              tests_passed_o;
  logic              tests_failed_o;
  logic              exit_valid_o;
  logic [DATA_W-1:0] exit_value_o;

  int unsigned cycle_cnt = 0;
  logic        prev_valid;
  logic [31:0] prev_rdata;

  `include "mm_ram_model.svh"

  mm_ram_top #(
    .RAM_ADDR_WIDTH(RAM_AW),
    .NUM_BANKS     (NUM_BANKS)
  ) i_mm_ram_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_req_valid_i(data_req_valid_i),
    .data_req_i      (data_req_i),
    .data_gnt_o      (data_gnt_o),
    .data_rvalid_o   (data_rvalid_o),
    .data_rdata_o    (data_rdata_o),
    .irq_ack_i       (irq_ack_i),
    .irq_id_i        (irq_id_i),
    .irq_timer_o     (irq_timer_o),
    .print_valid_o   (print_valid_o),
    .print_wdata_o   (print_wdata_o),
    .tests_passed_o  (tests_passed_o),
    .tests_failed_o  (tests_failed_o),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic data_req_t make_req(logic [31:0] addr, logic we, logic [3:0] be,
                                         logic [31:0] wdata);
    data_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  // one bus cycle that drives, checks outputs mid cycle and then steps the model
  task automatic run_cycle(string name, logic valid, data_req_t req, logic ack, logic [4:0] id);
    pulse_t      exp_p;
    logic [31:0] exp_rd;
    @(posedge clk_i);
    #1;
    data_req_valid_i = valid;
    data_req_i       = req;
    irq_ack_i        = ack;
    irq_id_i         = id;
    exp_p  = expected_pulses(valid, req);
    exp_rd = expected_rdata(req);
    @(negedge clk_i);
    check_value({name, " gnt"}, valid, data_gnt_o);
    check_value({name, " rvalid"}, prev_valid, data_rvalid_o);
    if (prev_valid) begin
      check_value({name, " rdata"}, prev_rdata, data_rdata_o);
    end
    check_value({name, " irq"}, irq_m, irq_timer_o);
    check_value({name, " print"}, exp_p.print, print_valid_o);
    check_value({name, " passed"}, exp_p.passed, tests_passed_o);
    check_value({name, " failed"}, exp_p.failed, tests_failed_o);
    check_value({name, " exit"}, exp_p.exit_v, exit_valid_o);
    if (exp_p.print) begin
      check_value({name, " print data"}, req.wdata, print_wdata_o);
    end
    if (exp_p.exit_v) begin
      check_value({name, " exit value"}, exp_p.exit_value, exit_value_o);
    end
    prev_valid = valid;
    prev_rdata = exp_rd;
    advance_model(valid, req, ack, id);
  endtask

  task automatic fill_ram();
    logic [31:0] addr;
    for (int w = 0; w < RAM_WORDS; w++) begin
      addr = w * 4;
      // pattern mixes every address bit
      run_cycle("fill", 1'b1,
                make_req(addr, 1'b1, 4'hf, (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]}),
                1'b0, '0);
    end
  endtask

  task automatic random_ram_traffic(int unsigned n);
    int unsigned kind;
    logic [31:0] addr;
    for (int i = 0; i < n; i++) begin
      kind = $urandom_range(0, 9);
      addr = $urandom_range(0, RAM_WORDS - 1) * 4;
      if (kind == 0) begin
        run_cycle("idle", 1'b0, make_req('0, 1'b0, '0, '0), 1'b0, '0);
      end else if (kind == 1) begin
        // far above the map and never a control address
        addr = {1'b1, 29'($urandom), 2'b00};
        run_cycle("unmapped", 1'b1, make_req(addr, 1'($urandom), 4'hf, $urandom), 1'b0, '0);
      end else if (kind < 5) begin
        run_cycle("ram write", 1'b1, make_req(addr, 1'b1, 4'($urandom_range(1, 15)), $urandom),
                  1'b0, '0);
      end else begin
        run_cycle("ram read", 1'b1, make_req(addr, 1'b0, '0, '0), 1'b0, '0);
      end
    end
  endtask

  task automatic ctrl_writes(int unsigned n);
    logic [31:0] addr;
    logic [31:0] wdata;
    for (int i = 0; i < n; i++) begin
      case ($urandom_range(0, 3))
        0:       addr = PRINT_ADDR;
        1:       addr = EXIT_ADDR;
        2:       addr = EXIT_ZERO_ADDR;
        default: addr = TEST_STATUS_ADDR;
      endcase
      case ($urandom_range(0, 2))
        0:       wdata = TEST_PASS_CODE;
        1:       wdata = TEST_FAIL_CODE;
        default: wdata = $urandom;
      endcase
      // a few reads that answer with zero
      run_cycle("ctrl", 1'b1, make_req(addr, ($urandom_range(0, 7) != 0), 4'hf, wdata),
                1'b0, '0);
    end
  endtask

  task automatic timer_trials(int unsigned n);
    logic [31:0] mask;
    logic [4:0]  id;
    for (int i = 0; i < n; i++) begin
      mask = $urandom;
      mask[TIMER_IRQ_ID] = 1'($urandom_range(0, 1));
      run_cycle("timer mask", 1'b1, make_req(TIMER_MASK_ADDR, 1'b1, 4'hf, mask), 1'b0, '0);
      run_cycle("timer load", 1'b1,
                make_req(TIMER_CNT_ADDR, 1'b1, 4'hf, $urandom_range(1, 40)), 1'b0, '0);
      while (timer_cnt_m != 0) begin
        run_cycle("timer count", 1'($urandom_range(0, 1)),
                  make_req(TIMER_CNT_ADDR, 1'b0, '0, '0), 1'b0, '0);
      end
      run_cycle("timer expired", 1'b1, make_req(TIMER_CNT_ADDR, 1'b0, '0, '0), 1'b0, '0);
      repeat ($urandom_range(1, 3)) begin
        id = 5'($urandom_range(0, 31));
        if (id == TIMER_IRQ_ID) begin
          id = id + 5'd1;
        end
        run_cycle("irq other id", 1'b0, make_req('0, 1'b0, '0, '0), 1'b1, id);
      end
      run_cycle("irq ack", 1'b0, make_req('0, 1'b0, '0, '0), 1'b1, TIMER_IRQ_ID);
      run_cycle("irq cleared", 1'b0, make_req('0, 1'b0, '0, '0), 1'b0, '0);
    end
  endtask

  initial begin
    rst_ni           = 1'b0;
    data_req_valid_i = 1'b0;
    data_req_i       = '0;
    irq_ack_i        = 1'b0;
    irq_id_i         = '0;
    prev_valid       = 1'b0;
    prev_rdata       = '0;
    timer_cnt_m      = '0;
    timer_mask_m     = '0;
    irq_m            = 1'b0;
    void'($urandom(11303));
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    fill_ram();
    random_ram_traffic(1500);
    ctrl_writes(200);
    timer_trials(24);
    // drain the last response
    run_cycle("drain", 1'b0, make_req('0, 1'b0, '0, '0), 1'b0, '0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: compile.f
+incdir+tests
hw/mm_ram_pkg.sv
hw/mm_addr_decode.sv
hw/mm_ram_bank.sv
hw/mm_ctrl_regs.sv
hw/mm_resp_mux.sv
hw/mm_ram_top.sv
tests/mm_ram_tb.sv
